/* rtl/sobel_pkg.sv */
// **************************************************************************
// Frame geometry is fixed at compile time; pixels are 8-bit unsigned grey
// **************************************************************************
package sobel_pkg;

    // Source frame size
    localparam int IMG_W = 16;
    localparam int IMG_H = 12;
    localparam int NUM_PIXELS = IMG_W * IMG_H;

    // Compact result holds interior pixels only
    localparam int NUM_RESULTS = (IMG_W - 2) * (IMG_H - 2);

    localparam int ADDR_W = $clog2(NUM_PIXELS);

    typedef logic [7:0] pixel_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // 3x3 neighbourhood, row 0 is the oldest line
    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p02;
        pixel_t p10;
        pixel_t p11;
        pixel_t p12;
        pixel_t p20;
        pixel_t p21;
        pixel_t p22;
    } window_t;

endpackage

/* rtl/pixel_stream_if.sv */
// **************************************************************************
// Raster pixel stream; valid and data hold until valid and ready meet
// **************************************************************************
interface pixel_stream_if import sobel_pkg::*; ();

    logic   valid;
    logic   ready;
    pixel_t pixel;
    // Final pixel of the frame
    logic   last;

    modport source (
        output valid,
        output pixel,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  pixel,
        input  last,
        output ready
    );

endinterface

/* rtl/window_stream_if.sv */
// **************************************************************************
// 3x3 window stream; valid and data hold until valid and ready meet
// **************************************************************************
interface window_stream_if import sobel_pkg::*; ();

    logic    valid;
    logic    ready;
    window_t window;
    // Final interior window of the frame
    logic    last;

    modport source (
        output valid,
        output window,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  window,
        input  last,
        output ready
    );

endinterface

/* rtl/frame_ram.sv */
// **************************************************************************
// Read data appears one cycle after raddr; no read-during-write bypass
// **************************************************************************
module frame_ram import sobel_pkg::*; (
    input  logic   clk_i,
    input  logic   we,
    input  addr_t  waddr,
    input  pixel_t wdata,
    input  addr_t  raddr,
    output pixel_t rdata
);

    pixel_t mem [0:NUM_PIXELS-1];

    // Write port
    always_ff @(posedge clk_i) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        rdata <= mem[raddr];
    end

endmodule

/* rtl/frame_reader.sv */
// **************************************************************************
// Source RAM must not be written while busy; start while busy is ignored
// **************************************************************************
module frame_reader import sobel_pkg::*; (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           start,
    output logic           busy,
    output addr_t          ram_addr,
    input  pixel_t         ram_data,
    pixel_stream_if.source pix,
    input  logic           frame_done
);

    logic  run;
    logic  inflight;
    logic  issue_done;
    addr_t next_addr;
    addr_t cur_addr;
    logic  load;
    logic  step;

    // Busy drops in the same cycle the writer reports done
    assign busy = run && !frame_done;

    // RAM data lands in the output register when it is empty or being taken
    assign load = inflight && (!pix.valid || pix.ready);

    // New read only when the pending one moves on
    assign step = run && !issue_done && (!inflight || load);

    // Re-reading the pending address keeps ram_data stable during a stall
    assign ram_addr = step ? next_addr : cur_addr;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            run        <= 1'b0;
            inflight   <= 1'b0;
            issue_done <= 1'b0;
            next_addr  <= '0;
            cur_addr   <= '0;
            pix.valid  <= 1'b0;
        end else begin
            if (run && frame_done) begin
                run <= 1'b0;
            end
            if (step) begin
                cur_addr  <= next_addr;
                next_addr <= next_addr + 1'b1;
                if (next_addr == addr_t'(NUM_PIXELS - 1)) begin
                    issue_done <= 1'b1;
                end
            end
            if (start && !busy) begin
                run        <= 1'b1;
                issue_done <= 1'b0;
                next_addr  <= '0;
            end

            if (step) begin
                inflight <= 1'b1;
            end else if (load) begin
                inflight <= 1'b0;
            end

            if (load) begin
                pix.valid <= 1'b1;
            end else if (pix.ready) begin
                pix.valid <= 1'b0;
            end
        end
    end

    // Output pixel register
    always_ff @(posedge clk_i) begin
        if (load) begin
            pix.pixel <= ram_data;
            pix.last  <= (cur_addr == addr_t'(NUM_PIXELS - 1));
        end
    end

endmodule

/* rtl/line_cache.sv */
// **************************************************************************
// Windows only for interior centres; input frame must end with last set
// **************************************************************************
module line_cache import sobel_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_i,
    pixel_stream_if.sink    pix,
    window_stream_if.source win
);

    // Two rows up and one row up
    pixel_t line_old [0:IMG_W-1];
    pixel_t line_mid [0:IMG_W-1];

    logic [$clog2(IMG_W)-1:0] col;
    logic [$clog2(IMG_H)-1:0] row;
    window_t                  wnd;
    logic                     accept;
    logic                     interior;

    assign pix.ready = !win.valid || win.ready;
    assign accept    = pix.valid && pix.ready;

    // Incoming pixel is the bottom right corner of a full window
    assign interior = (row >= 2) && (col >= 2);

    assign win.window = wnd;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            row       <= '0;
            col       <= '0;
            win.valid <= 1'b0;
        end else begin
            if (accept) begin
                if (pix.last) begin
                    row <= '0;
                    col <= '0;
                end else if (col == IMG_W - 1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
                win.valid <= interior;
            end else if (win.ready) begin
                win.valid <= 1'b0;
            end
        end
    end

    // Line memories and window shift
    always_ff @(posedge clk_i) begin
        if (accept) begin
            line_old[col] <= line_mid[col];
            line_mid[col] <= pix.pixel;

            wnd.p00 <= wnd.p01;
            wnd.p01 <= wnd.p02;
            wnd.p02 <= line_old[col];
            wnd.p10 <= wnd.p11;
            wnd.p11 <= wnd.p12;
            wnd.p12 <= line_mid[col];
            wnd.p20 <= wnd.p21;
            wnd.p21 <= wnd.p22;
            wnd.p22 <= pix.pixel;

            win.last <= pix.last;
        end
    end

endmodule

/* rtl/sobel_kernel.sv */
// **************************************************************************
// Two-cycle latency; a low res_ready freezes both stages and the input
// **************************************************************************
module sobel_kernel import sobel_pkg::*; (
    input  logic          clk_i,
    input  logic          rst_i,
    window_stream_if.sink win,
    output logic          res_valid,
    input  logic          res_ready,
    output pixel_t        res_pixel,
    output logic          res_last
);

    logic               adv;
    logic               s1_valid;
    logic               s1_last;
    logic signed [10:0] gx;
    logic signed [10:0] gy;
    logic [9:0]         gx_pos;
    logic [9:0]         gx_neg;
    logic [9:0]         gy_pos;
    logic [9:0]         gy_neg;
    logic [10:0]        abs_x;
    logic [10:0]        abs_y;
    logic [11:0]        mag;

    assign adv       = !res_valid || res_ready;
    assign win.ready = adv;

    // 1-2-1 weighted column and row sums
    always_comb begin
        gx_pos = {2'b00, win.window.p02} + {1'b0, win.window.p12, 1'b0}
               + {2'b00, win.window.p22};
        gx_neg = {2'b00, win.window.p00} + {1'b0, win.window.p10, 1'b0}
               + {2'b00, win.window.p20};
        gy_pos = {2'b00, win.window.p20} + {1'b0, win.window.p21, 1'b0}
               + {2'b00, win.window.p22};
        gy_neg = {2'b00, win.window.p00} + {1'b0, win.window.p01, 1'b0}
               + {2'b00, win.window.p02};
    end

    always_comb begin
        abs_x = gx[10] ? -gx : gx;
        abs_y = gy[10] ? -gy : gy;
        mag   = {1'b0, abs_x} + {1'b0, abs_y};
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else if (adv) begin
            s1_valid  <= win.valid;
            res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (adv) begin
            // Stage one, signed gradients
            gx      <= $signed({1'b0, gx_pos}) - $signed({1'b0, gx_neg});
            gy      <= $signed({1'b0, gy_pos}) - $signed({1'b0, gy_neg});
            s1_last <= win.last;
            // Stage two, saturate at full scale
            res_pixel <= (|mag[11:8]) ? 8'hff : mag[7:0];
            res_last  <= s1_last;
        end
    end

endmodule

/* rtl/result_writer.sv */
// **************************************************************************
// Always ready; start is ignored between start and the last result
// **************************************************************************
module result_writer import sobel_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   start,
    input  logic   res_valid,
    output logic   res_ready,
    input  pixel_t res_pixel,
    input  logic   res_last,
    output logic   ram_we,
    output addr_t  ram_addr,
    output pixel_t ram_data,
    output logic   done
);

    logic  armed;
    logic  take;
    addr_t wr_addr;

    assign res_ready = 1'b1;
    assign take      = res_valid && res_ready;

    // Write happens on the transfer edge
    assign ram_we   = take;
    assign ram_addr = wr_addr;
    assign ram_data = res_pixel;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            armed   <= 1'b0;
            wr_addr <= '0;
            done    <= 1'b0;
        end else if (start && !armed) begin
            armed   <= 1'b1;
            wr_addr <= '0;
            done    <= 1'b0;
        end else if (take) begin
            wr_addr <= wr_addr + 1'b1;
            if (res_last) begin
                armed <= 1'b0;
                done  <= 1'b1;
            end
        end
    end

endmodule

/* rtl/edge_detect_top.sv */
// **************************************************************************
// Load the source frame while idle; results are read back after done
// **************************************************************************
module edge_detect_top import sobel_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_i,
    input  logic   start,
    input  logic   load_we,
    input  addr_t  load_addr,
    input  pixel_t load_data,
    input  addr_t  res_addr,
    output pixel_t res_data,
    output logic   busy,
    output logic   done
);

    addr_t  src_raddr;
    pixel_t src_rdata;
    logic   res_valid;
    logic   res_ready;
    pixel_t res_pixel;
    logic   res_last;
    logic   dst_we;
    addr_t  dst_waddr;
    pixel_t dst_wdata;

    pixel_stream_if  pix_if ();
    window_stream_if win_if ();

    // Source frame
    frame_ram u_src_ram (
        .clk_i (clk_i),
        .we    (load_we),
        .waddr (load_addr),
        .wdata (load_data),
        .raddr (src_raddr),
        .rdata (src_rdata)
    );

    frame_reader u_reader (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start      (start),
        .busy       (busy),
        .ram_addr   (src_raddr),
        .ram_data   (src_rdata),
        .pix        (pix_if.source),
        .frame_done (done)
    );

    line_cache u_cache (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .pix   (pix_if.sink),
        .win   (win_if.source)
    );

    sobel_kernel u_kernel (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .win       (win_if.sink),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_pixel (res_pixel),
        .res_last  (res_last)
    );

    result_writer u_writer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start     (start),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_pixel (res_pixel),
        .res_last  (res_last),
        .ram_we    (dst_we),
        .ram_addr  (dst_waddr),
        .ram_data  (dst_wdata),
        .done      (done)
    );

    // Result frame, compact raster from address 0
    frame_ram u_dst_ram (
        .clk_i (clk_i),
        .we    (dst_we),
        .waddr (dst_waddr),
        .wdata (dst_wdata),
        .raddr (res_addr),
        .rdata (res_data)
    );

endmodule

/* bench/edge_detect_tb.sv */
// **************************************************************************
// Directed frames through the whole edge detector; stops at the first error
// **************************************************************************
module edge_detect_tb import sobel_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Frames run over all tests, the restart test included
    localparam int NUM_FRAMES      = 5;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * NUM_PIXELS * 4 + 500;

    logic   clk_i;
    logic   rst_i;
    logic   start;
    logic   load_we;
    addr_t  load_addr;
    pixel_t load_data;
    addr_t  res_addr;
    pixel_t res_data;
    logic   busy;
    logic   done;

    // Copy of the loaded image and the expected compact result
    pixel_t image    [0:NUM_PIXELS-1];
    pixel_t expected [0:NUM_RESULTS-1];
    int     seed;

    edge_detect_top uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start     (start),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .res_addr  (res_addr),
        .res_data  (res_data),
        .busy      (busy),
        .done      (done)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired before all tests finished");
        stop_on_failure();
    end

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            stop_on_failure();
        end
    endtask

    function automatic int pixel_at(input int r, input int c);
        return int'(image[r * IMG_W + c]);
    endfunction

    // Sobel magnitude of every interior pixel, saturated at 255
    task automatic compute_expected();
        int gx;
        int gy;
        int mag;
        for (int r = 1; r < IMG_H - 1; r++) begin
            for (int c = 1; c < IMG_W - 1; c++) begin
                gx = pixel_at(r - 1, c + 1) + 2 * pixel_at(r, c + 1) + pixel_at(r + 1, c + 1)
                   - pixel_at(r - 1, c - 1) - 2 * pixel_at(r, c - 1) - pixel_at(r + 1, c - 1);
                gy = pixel_at(r + 1, c - 1) + 2 * pixel_at(r + 1, c) + pixel_at(r + 1, c + 1)
                   - pixel_at(r - 1, c - 1) - 2 * pixel_at(r - 1, c) - pixel_at(r - 1, c + 1);
                mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
                expected[(r - 1) * (IMG_W - 2) + (c - 1)] = (mag > 255) ? 8'hff : pixel_t'(mag);
            end
        end
    endtask

    task automatic load_frame();
        for (int i = 0; i < NUM_PIXELS; i++) begin
            @(posedge clk_i);
            #2;
            load_we   = 1'b1;
            load_addr = addr_t'(i);
            load_data = image[i];
        end
        @(posedge clk_i);
        #2;
        load_we = 1'b0;
    endtask

    // Optionally pokes start again while the frame is still running
    task automatic run_frame(input bit poke_while_busy);
        @(posedge clk_i);
        #2;
        start = 1'b1;
        @(posedge clk_i);
        #2;
        start = 1'b0;
        check_flag("busy", busy, 1'b1);
        check_flag("done", done, 1'b0);
        if (poke_while_busy) begin
            repeat (20) @(posedge clk_i);
            #2;
            start = 1'b1;
            @(posedge clk_i);
            #2;
            start = 1'b0;
            check_flag("busy", busy, 1'b1);
            check_flag("done", done, 1'b0);
        end
        while (done !== 1'b1) begin
            @(posedge clk_i);
            #2;
        end
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic read_and_check();
        for (int i = 0; i < NUM_RESULTS; i++) begin
            @(posedge clk_i);
            #2;
            res_addr = addr_t'(i);
            @(posedge clk_i);
            #2;
            check_pixel($sformatf("res_data[%0d]", i), res_data, expected[i]);
        end
    endtask

    task automatic idle_after_reset();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    task automatic flat_image();
        for (int i = 0; i < NUM_PIXELS; i++) begin
            image[i] = 8'd90;
        end
        for (int i = 0; i < NUM_RESULTS; i++) begin
            expected[i] = 8'd0;
        end
        load_frame();
        run_frame(1'b0);
        read_and_check();
    endtask

    // Step between columns 7 and 8, so centres 7 and 8 see 160
    task automatic vertical_step();
        int c;
        for (int i = 0; i < NUM_PIXELS; i++) begin
            image[i] = ((i % IMG_W) < 8) ? 8'd0 : 8'd40;
        end
        compute_expected();
        for (int i = 0; i < NUM_RESULTS; i++) begin
            c = i % (IMG_W - 2) + 1;
            check_pixel("model", expected[i], (c == 7 || c == 8) ? 8'd160 : 8'd0);
        end
        load_frame();
        run_frame(1'b0);
        read_and_check();
    endtask

    // 2x2 blocks, so both gradients reach 510 before saturation
    task automatic checkerboard_saturation();
        int r;
        int c;
        for (int i = 0; i < NUM_PIXELS; i++) begin
            r = i / IMG_W;
            c = i % IMG_W;
            image[i] = (((r / 2) + (c / 2)) % 2 == 1) ? 8'hff : 8'h00;
        end
        for (int i = 0; i < NUM_RESULTS; i++) begin
            expected[i] = 8'hff;
        end
        load_frame();
        run_frame(1'b0);
        read_and_check();
    endtask

    task automatic random_image();
        for (int i = 0; i < NUM_PIXELS; i++) begin
            image[i] = pixel_t'($random(seed));
        end
        compute_expected();
        load_frame();
        run_frame(1'b0);
        read_and_check();
    endtask

    // Vertical ramp replaces the random results
    task automatic restart_with_ramp();
        check_flag("done", done, 1'b1);
        for (int i = 0; i < NUM_PIXELS; i++) begin
            image[i] = pixel_t'((i / IMG_W) * 20);
        end
        compute_expected();
        load_frame();
        run_frame(1'b1);
        read_and_check();
    endtask

    initial begin
        rst_i     = 1'b1;
        start     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        res_addr  = '0;
        seed      = 6;
        repeat (10) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        idle_after_reset();
        flat_image();
        vertical_step();
        checkerboard_saturation();
        random_image();
        restart_with_ramp();

        $display("Test passed");
        $finish;
    end

endmodule

/* all.f */
rtl/sobel_pkg.sv
rtl/pixel_stream_if.sv
rtl/window_stream_if.sv
rtl/frame_ram.sv
rtl/frame_reader.sv
rtl/line_cache.sv
rtl/sobel_kernel.sv
rtl/result_writer.sv
rtl/edge_detect_top.sv
bench/edge_detect_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= edge_detect_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
